/* compile.f */
design/oflow_pkg.sv
design/oflow_frame_writer.sv
design/oflow_history_mem.sv
design/oflow_fsm_read.sv
design/oflow_line_reader.sv
design/oflow_history_buffer.sv
testbench/tb_oflow_history_buffer.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_oflow_history_buffer
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/tb_oflow_history_buffer.sv */
/*
 * history buffer testbench
 * random frames written into the slots, history reads checked
 * against a slot model kept in the testbench
 */
`timescale 1ns/10ps

module tb_oflow_history_buffer;

	localparam int NUM_SLOTS  = 5;
	localparam int ADDR_WIDTH = 4;
	localparam int DATA_WIDTH = 32;
	localparam int FW = oflow_pkg::TOTAL_FRAME_NUM_WIDTH;
	localparam int HW = oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH;
	localparam int CLK_PERIOD = 20;
	// 14 frames written and 15 frames read, at most 15 lines each
	localparam int MAX_LINES  = 435;
	// cycles allowed per line, back-pressure included
	localparam int LINE_BOUND = 40;
	localparam int WATCHDOG_CYCLES = MAX_LINES * LINE_BOUND + 200;

	logic clk;
	logic reset_N;
	logic [FW-1:0] frame_num;
	logic [HW-1:0] num_of_history_frames;
	logic in_valid;
	logic [DATA_WIDTH-1:0] in_line;
	logic in_last;
	logic start_read;
	logic out_ready;
	logic done_read;
	logic out_valid;
	logic [DATA_WIDTH-1:0] out_line;
	logic [FW-1:0] out_frame;
	logic [ADDR_WIDTH-1:0] out_offset;

	integer seed;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int base;

	// ------------------------------
	// slot model
	// ------------------------------

	// owner frame per slot, -1 when never written
	int slot_owner [NUM_SLOTS];
	int slot_len [NUM_SLOTS];
	logic [DATA_WIDTH-1:0] slot_data [NUM_SLOTS][2**ADDR_WIDTH];
	// predicted output sequence
	logic [DATA_WIDTH-1:0] exp_line [$];
	logic [FW-1:0] exp_frame [$];
	logic [ADDR_WIDTH-1:0] exp_offset [$];

	oflow_history_buffer #(
		.NUM_SLOTS(NUM_SLOTS), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) i_oflow_history_buffer (
		.clk(clk), .reset_N(reset_N), .frame_num(frame_num),
		.num_of_history_frames(num_of_history_frames),
		.in_valid(in_valid), .in_line(in_line), .in_last(in_last),
		.start_read(start_read), .done_read(done_read),
		.out_ready(out_ready), .out_valid(out_valid), .out_line(out_line),
		.out_frame(out_frame), .out_offset(out_offset)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// watchdog, bound from total lines
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic report_error(input string msg);
		count_error();
		$display("ERROR at time %0t: %s", $time, msg);
	endtask

	task automatic check_line(input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			count_error();
			$display("CHECK FAILED time %0t out_line expected %h actual %h",
				$time, expected, actual);
		end
	endtask

	task automatic check_frame(input logic [FW-1:0] expected, input logic [FW-1:0] actual);
		if (actual !== expected) begin
			count_error();
			$display("CHECK FAILED time %0t out_frame expected %0d actual %0d",
				$time, expected, actual);
		end
	endtask

	task automatic check_offset(input logic [ADDR_WIDTH-1:0] expected,
		input logic [ADDR_WIDTH-1:0] actual);
		if (actual !== expected) begin
			count_error();
			$display("CHECK FAILED time %0t out_offset expected %0d actual %0d",
				$time, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			count_error();
			$display("CHECK FAILED time %0t %s expected %b actual %b",
				$time, name, expected, actual);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	// reset clears end pointers, so the model forgets all slots
	task automatic apply_reset();
		@(negedge clk);
		reset_N = 1'b0;
		repeat (10) @(negedge clk);
		reset_N = 1'b1;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			slot_owner[s] = -1;
			slot_len[s] = 0;
		end
	endtask

	// one frame of n lines, random idle gaps
	task automatic write_frame(input int frame, input int n);
		int slot;
		slot = frame % int'(num_of_history_frames);
		slot_owner[slot] = frame;
		slot_len[slot] = n;
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			frame_num = FW'(frame);
			if (($random(seed) & 7) == 0) begin
				in_valid = 1'b0;
				@(negedge clk);
			end
			in_valid = 1'b1;
			in_line = $random(seed);
			in_last = (i == n - 1);
			slot_data[slot][i] = in_line;
		end
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	// newest history frame first, each slot from offset 0
	task automatic predict_read();
		int f;
		int s;
		int depth;
		depth = int'(num_of_history_frames);
		exp_line.delete();
		exp_frame.delete();
		exp_offset.delete();
		for (int k = 1; k <= depth; k++) begin
			f = (int'(frame_num) - k + 256) % 256;
			s = f % depth;
			if (slot_owner[s] >= 0) begin
				for (int o = 0; o < slot_len[s]; o++) begin
					exp_line.push_back(slot_data[s][o]);
					exp_frame.push_back(FW'(f));
					exp_offset.push_back(ADDR_WIDTH'(o));
				end
			end
		end
	endtask

	// outputs sampled on the falling edge, handshake at the next rising edge
	task automatic run_read(input bit backpressure);
		int cycles;
		int limit;
		int done_count;
		bit ready;
		predict_read();
		limit = exp_line.size() * LINE_BOUND + 50;
		cycles = 0;
		done_count = 0;
		@(negedge clk);
		start_read = 1'b1;
		@(negedge clk);
		start_read = 1'b0;
		while (done_count == 0 && cycles < limit) begin
			ready = backpressure ? (($random(seed) & 1) == 1) : 1'b1;
			out_ready = ready;
			if (out_valid && ready) begin
				if (exp_line.size() == 0) begin
					report_error($sformatf("extra line for frame %0d offset %0d",
						out_frame, out_offset));
				end else begin
					check_line(exp_line.pop_front(), out_line);
					check_frame(exp_frame.pop_front(), out_frame);
					check_offset(exp_offset.pop_front(), out_offset);
				end
			end
			if (done_read)
				done_count++;
			@(negedge clk);
			cycles++;
		end
		out_ready = 1'b0;
		if (done_count == 0) begin
			report_error($sformatf("done_read did not arrive within %0d cycles", limit));
		end else begin
			if (exp_line.size() != 0)
				report_error($sformatf("%0d lines were never delivered", exp_line.size()));
			// pulse lasts one cycle
			check_flag("done_read", 1'b0, done_read);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		seed = 93;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_N = 1'b0;
		frame_num = '0;
		num_of_history_frames = HW'(5);
		in_valid = 1'b0;
		in_line = '0;
		in_last = 1'b0;
		start_read = 1'b0;
		out_ready = 1'b0;
		apply_reset();

		// idle after reset
		repeat (20) begin
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid);
			check_flag("done_read", 1'b0, done_read);
		end
		finish_test("idle after reset");

		// five frames, full depth
		base = 8 + ($unsigned($random(seed)) % 64);
		for (int k = 0; k < 5; k++)
			write_frame(base + k, 1 + ($unsigned($random(seed)) % 15));
		frame_num = FW'(base + 5);
		run_read(1'b0);
		finish_test("full history read");

		// same history again under random out_ready
		run_read(1'b1);
		finish_test("read with back-pressure");

		// oldest requested slot never written
		num_of_history_frames = HW'(3);
		apply_reset();
		base = 8 + ($unsigned($random(seed)) % 64);
		write_frame(base, 1 + ($unsigned($random(seed)) % 15));
		write_frame(base + 1, 1 + ($unsigned($random(seed)) % 15));
		frame_num = FW'(base + 2);
		run_read(1'b0);
		finish_test("empty slot skipped");

		// seven frames over three slots
		apply_reset();
		base = 8 + ($unsigned($random(seed)) % 64);
		for (int k = 0; k < 7; k++)
			write_frame(base + k, 1 + ($unsigned($random(seed)) % 15));
		frame_num = FW'(base + 7);
		run_read(1'b1);
		finish_test("slot reuse");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* design/oflow_history_buffer.sv */
/*
 * optical-flow history frame buffer, top level
 * writer, line memory, history read FSM and line reader
 */
`timescale 1ns/10ps

module oflow_history_buffer #(
	parameter int NUM_SLOTS  = 5,
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic clk,
	input  logic reset_N,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	// write stream
	input  logic in_valid,
	input  logic [DATA_WIDTH-1:0] in_line,
	input  logic in_last,
	// read control
	input  logic start_read,
	output logic done_read,
	// output stream
	input  logic out_ready,
	output logic out_valid,
	output logic [DATA_WIDTH-1:0] out_line,
	output logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] out_frame,
	output logic [ADDR_WIDTH-1:0] out_offset
);

	// ------------------------------
	// internal wires
	// ------------------------------

	// writer to memory and FSM
	logic mem_we;
	logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_wslot;
	logic [ADDR_WIDTH-1:0] mem_waddr;
	logic [DATA_WIDTH-1:0] mem_wdata;
	logic [ADDR_WIDTH-1:0] end_pointers [NUM_SLOTS];
	// reader and memory
	logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_rslot;
	logic [ADDR_WIDTH-1:0] mem_raddr;
	logic [DATA_WIDTH-1:0] mem_rdata;
	// FSM and reader
	logic line_req;
	logic line_taken;
	logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_to_read;
	logic [ADDR_WIDTH-1:0] offset_0;

	oflow_frame_writer #(
		.NUM_SLOTS(NUM_SLOTS), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) i_frame_writer (
		.clk(clk), .reset_N(reset_N), .frame_num(frame_num),
		.num_of_history_frames(num_of_history_frames),
		.in_valid(in_valid), .in_line(in_line), .in_last(in_last),
		.mem_we(mem_we), .mem_wslot(mem_wslot), .mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata), .end_pointers(end_pointers)
	);

	oflow_history_mem #(
		.NUM_SLOTS(NUM_SLOTS), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) i_history_mem (
		.clk(clk), .mem_we(mem_we), .mem_wslot(mem_wslot), .mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata), .mem_rslot(mem_rslot), .mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata)
	);

	oflow_fsm_read #(
		.NUM_SLOTS(NUM_SLOTS), .ADDR_WIDTH(ADDR_WIDTH)
	) i_fsm_read (
		.clk(clk), .reset_N(reset_N), .frame_num(frame_num),
		.num_of_history_frames(num_of_history_frames), .end_pointers(end_pointers),
		.start_read(start_read), .line_taken(line_taken), .done_read(done_read),
		.line_req(line_req), .frame_to_read(frame_to_read), .offset_0(offset_0)
	);

	oflow_line_reader #(
		.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) i_line_reader (
		.clk(clk), .reset_N(reset_N), .num_of_history_frames(num_of_history_frames),
		.line_req(line_req), .frame_to_read(frame_to_read), .offset_0(offset_0),
		.mem_rdata(mem_rdata), .mem_rslot(mem_rslot), .mem_raddr(mem_raddr),
		.line_taken(line_taken), .out_ready(out_ready), .out_valid(out_valid),
		.out_line(out_line), .out_frame(out_frame), .out_offset(out_offset)
	);

endmodule

/* design/oflow_line_reader.sv */
/*
 * line reader
 * fetches a requested line from history memory and presents it
 * to the similarity-metric consumer under valid/ready
 */
`timescale 1ns/10ps

module oflow_line_reader #(
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic clk,
	input  logic reset_N,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	// request from read FSM
	input  logic line_req,
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_to_read,
	input  logic [ADDR_WIDTH-1:0] offset_0,
	// memory read port
	input  logic [DATA_WIDTH-1:0] mem_rdata,
	output logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_rslot,
	output logic [ADDR_WIDTH-1:0] mem_raddr,
	// back to the FSM
	output logic line_taken,
	// consumer side
	input  logic out_ready,
	output logic out_valid,
	output logic [DATA_WIDTH-1:0] out_line,
	output logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] out_frame,
	output logic [ADDR_WIDTH-1:0] out_offset
);

	oflow_pkg::reader_state_t state;

	// ------------------------------
	// memory address
	// ------------------------------

	// FSM holds frame and offset until the line is taken
	assign mem_rslot = oflow_pkg::frame_slot(frame_to_read, num_of_history_frames);
	assign mem_raddr = offset_0;

	// ------------------------------
	// control
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_pkg::rd_idle_st;
		end else begin
			case (state)
				oflow_pkg::rd_idle_st: if (line_req) state <= oflow_pkg::rd_fetch_st;
				// memory data lands during fetch
				oflow_pkg::rd_fetch_st: state <= oflow_pkg::rd_present_st;
				oflow_pkg::rd_present_st: if (out_ready) state <= oflow_pkg::rd_idle_st;
				default: state <= oflow_pkg::rd_idle_st;
			endcase
		end
	end

	// ------------------------------
	// payload
	// ------------------------------

	always_ff @(posedge clk) begin
		// tag captured with the address
		if (state == oflow_pkg::rd_idle_st && line_req) begin
			out_frame  <= frame_to_read;
			out_offset <= offset_0;
		end
		// line held until handshake
		if (state == oflow_pkg::rd_fetch_st)
			out_line <= mem_rdata;
	end

	assign out_valid  = (state == oflow_pkg::rd_present_st);
	// one pulse per accepted line
	assign line_taken = out_valid && out_ready;

endmodule

/* design/oflow_fsm_read.sv */
/*
 * history read FSM
 * walks history frames newest to oldest and each frame's line offsets
 * from 0 up to the slot's end pointer
 */
`timescale 1ns/10ps

module oflow_fsm_read #(
	parameter int NUM_SLOTS  = 5,
	parameter int ADDR_WIDTH = 4
) (
	input  logic clk,
	input  logic reset_N,
	// current frame serial number 0-255
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	// history depth
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	// lines per slot, from the writer
	input  logic [ADDR_WIDTH-1:0] end_pointers [NUM_SLOTS],
	input  logic start_read,
	// line accepted downstream, ready for a new line
	input  logic line_taken,
	output logic done_read,
	output logic line_req,
	output logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_to_read,
	output logic [ADDR_WIDTH-1:0] offset_0
);

	localparam int FW = oflow_pkg::TOTAL_FRAME_NUM_WIDTH;
	localparam int HW = oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH;

	// ------------------------------
	// registers and wires
	// ------------------------------

	oflow_pkg::read_state_t state;
	oflow_pkg::read_state_t next_state;

	logic [HW-1:0] hist_cnt;
	logic [ADDR_WIDTH-1:0] offset_cnt;
	// zero-extended history counter for the frame arithmetic
	logic [FW-1:0] hist_ext;
	logic [HW-1:0] cur_slot;
	logic [ADDR_WIDTH-1:0] cur_end;
	logic load_frame;
	logic new_frame;

	assign hist_ext = {{(FW-HW){1'b0}}, hist_cnt};
	assign cur_slot = oflow_pkg::frame_slot(frame_to_read, num_of_history_frames);
	assign cur_end  = end_pointers[cur_slot];

	// ------------------------------
	// sequential part
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state         <= oflow_pkg::idle_st;
			hist_cnt      <= '0;
			offset_cnt    <= '0;
			frame_to_read <= '0;
		end else begin
			state <= next_state;
			// history counter
			if (state == oflow_pkg::idle_st)
				hist_cnt <= '0;
			else if (new_frame)
				hist_cnt <= hist_cnt + HW'(1);
			// offset counter, steps once per consumed line
			if (state == oflow_pkg::idle_st || new_frame)
				offset_cnt <= '0;
			else if (state == oflow_pkg::offset_st && line_taken)
				offset_cnt <= offset_cnt + ADDR_WIDTH'(1);
			// held through offset_st
			if (load_frame)
				frame_to_read <= frame_num - hist_ext - FW'(1);
		end
	end

	// ------------------------------
	// next state logic
	// ------------------------------

	always_comb begin
		next_state = state;
		load_frame = 1'b0;
		new_frame  = 1'b0;
		done_read  = 1'b0;
		case (state)
			oflow_pkg::idle_st: begin
				if (start_read)
					next_state = oflow_pkg::frame_st;
			end
			oflow_pkg::frame_st: begin
				if (hist_cnt < num_of_history_frames) begin
					load_frame = 1'b1;
					next_state = oflow_pkg::offset_st;
				end else begin
					// all history frames walked
					done_read  = 1'b1;
					next_state = oflow_pkg::idle_st;
				end
			end
			oflow_pkg::offset_st: begin
				// frame finished, or empty slot
				if (offset_cnt == cur_end) begin
					new_frame  = 1'b1;
					next_state = oflow_pkg::frame_st;
				end
			end
			default: next_state = oflow_pkg::idle_st;
		endcase
	end

	assign line_req = (state == oflow_pkg::offset_st) && (offset_cnt != cur_end);
	assign offset_0 = offset_cnt;

endmodule

/* design/oflow_history_mem.sv */
/*
 * history line memory
 * NUM_SLOTS frames of 2^ADDR_WIDTH lines, one write port, one registered read port
 */
`timescale 1ns/10ps

module oflow_history_mem #(
	parameter int NUM_SLOTS  = 5,
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic clk,
	// write port, from frame writer
	input  logic mem_we,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_wslot,
	input  logic [ADDR_WIDTH-1:0] mem_waddr,
	input  logic [DATA_WIDTH-1:0] mem_wdata,
	// read port, from line reader
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_rslot,
	input  logic [ADDR_WIDTH-1:0] mem_raddr,
	output logic [DATA_WIDTH-1:0] mem_rdata
);

	// ------------------------------
	// storage
	// ------------------------------

	// slot by line offset
	logic [DATA_WIDTH-1:0] mem [NUM_SLOTS][2**ADDR_WIDTH];

	// synchronous write
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_wslot][mem_waddr] <= mem_wdata;
	end

	// registered read
	// data one cycle after the address
	always_ff @(posedge clk) begin
		mem_rdata <= mem[mem_rslot][mem_raddr];
	end

endmodule

/* design/oflow_frame_writer.sv */
/*
 * frame writer
 * stores incoming pixel lines of the current frame into its history slot
 * and records the line count of each slot as its end pointer
 */
`timescale 1ns/10ps

module oflow_frame_writer #(
	parameter int NUM_SLOTS  = 5,
	parameter int ADDR_WIDTH = 4,
	parameter int DATA_WIDTH = 32
) (
	input  logic clk,
	input  logic reset_N,
	// frame info, stable during the frame
	input  logic [oflow_pkg::TOTAL_FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames,
	// line stream, always accepted
	input  logic in_valid,
	input  logic [DATA_WIDTH-1:0] in_line,
	input  logic in_last,
	// memory write port
	output logic mem_we,
	output logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] mem_wslot,
	output logic [ADDR_WIDTH-1:0] mem_waddr,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	// lines per slot, to the read FSM
	output logic [ADDR_WIDTH-1:0] end_pointers [NUM_SLOTS]
);

	// ------------------------------
	// line counter
	// ------------------------------

	// offset of the next line inside the frame
	logic [ADDR_WIDTH-1:0] line_cnt;
	// slot owned by the frame being written
	logic [oflow_pkg::NUM_OF_HISTORY_FRAMES_WIDTH-1:0] cur_slot;

	assign cur_slot = oflow_pkg::frame_slot(frame_num, num_of_history_frames);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			line_cnt <= '0;
		end else if (in_valid) begin
			// last line closes the frame, next frame starts at offset 0
			if (in_last)
				line_cnt <= '0;
			else
				line_cnt <= line_cnt + ADDR_WIDTH'(1);
		end
	end

	// ------------------------------
	// end pointers
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			// empty slots read back as zero lines
			for (int i = 0; i < NUM_SLOTS; i++)
				end_pointers[i] <= '0;
		end else if (in_valid && in_last) begin
			// count includes the last line itself
			end_pointers[cur_slot] <= line_cnt + ADDR_WIDTH'(1);
		end
	end

	// ------------------------------
	// memory write
	// ------------------------------

	// each accepted line goes straight to memory
	assign mem_we    = in_valid;
	assign mem_wslot = cur_slot;
	assign mem_waddr = line_cnt;
	assign mem_wdata = in_line;

endmodule

/* design/oflow_pkg.sv */
/*
 * optical-flow history buffer shared definitions
 * fixed widths, FSM state encodings and the frame-to-slot mapping
 */
package oflow_pkg;

	// frame serial number 0-255
	localparam int TOTAL_FRAME_NUM_WIDTH = 8;
	// history depth and history counter
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 3;

	// read FSM states
	typedef enum logic [1:0] {idle_st, frame_st, offset_st} read_state_t;

	// line reader states
	typedef enum logic [1:0] {rd_idle_st, rd_fetch_st, rd_present_st} reader_state_t;

	// slot of a frame is frame number modulo the run-time depth
	function automatic logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] frame_slot(
		input logic [TOTAL_FRAME_NUM_WIDTH-1:0] frame,
		input logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] depth
	);
		logic [TOTAL_FRAME_NUM_WIDTH-1:0] depth_ext;
		logic [TOTAL_FRAME_NUM_WIDTH-1:0] rem;
		depth_ext = {{(TOTAL_FRAME_NUM_WIDTH-NUM_OF_HISTORY_FRAMES_WIDTH){1'b0}}, depth};
		rem = frame % depth_ext;
		return rem[NUM_OF_HISTORY_FRAMES_WIDTH-1:0];
	endfunction

endpackage
